// File: bus_pkg.sv
// Internal request bus definitions
// Widths of the Wishbone side and the request and response records
// passed between decode, execute and result stages

package bus_pkg;

  //////////////////////////////
  // Bus widths
  //////////////////////////////

  localparam int unsigned data_width = 32;               // Wishbone data bus
  localparam int unsigned addr_width = 32;               // Wishbone byte address
  localparam int unsigned sel_width  = data_width / 8;   // One select bit per byte lane

  //////////////////////////////
  // Request to a target
  //////////////////////////////

  // Registered by the decoder on the sampling edge
  // Offset is the byte address inside the selected window
  typedef struct packed {
    logic                               we;      // 1 = write
    logic [sel_width-1:0]               sel;     // Byte lane enables
    logic [map_pkg::window_bits-1:0]    offset;  // Byte offset in window
    logic [data_width-1:0]              wdata;   // Write payload
  } tgt_req_t;

  //////////////////////////////
  // Response from a target
  //////////////////////////////

  // Valid for one cycle, one edge after the target strobe
  typedef struct packed {
    logic                  valid;   // Single cycle pulse
    logic [data_width-1:0] rdata;   // Zero for writes
  } tgt_rsp_t;

endpackage

// File: filelist.f
map_pkg.sv
bus_pkg.sv
wb_decoder.sv
sram_target.sv
sys_manager.sv
wb_responder.sv
main_partition.sv
tb_main_partition.sv

// File: main_partition.sv
// User partition top
// Wishbone slave in front of a 1 kB RAM and the system manager
// Decode, execute and result stages wired together

`timescale 1ns/1ps

module main_partition #(
  parameter int unsigned ram_words = 256          // RAM depth in words
) (
  input  logic                           wb_clk_i,
  input  logic                           rst_n_i,
  // Wishbone slave
  input  logic                           wbs_cyc_i,
  input  logic                           wbs_stb_i,
  input  logic                           wbs_we_i,
  input  logic [bus_pkg::sel_width-1:0]  wbs_sel_i,
  input  logic [bus_pkg::addr_width-1:0] wbs_adr_i,
  input  logic [bus_pkg::data_width-1:0] wbs_dat_i,
  output logic                           wbs_ack_o,
  output logic                           wbs_err_o,   // Unmapped address
  output logic [bus_pkg::data_width-1:0] wbs_dat_o,
  output logic                           proc_rst_n_o // Processor reset level
);

  //////////////////////////////
  // Internal request bus
  //////////////////////////////

  bus_pkg::tgt_req_t tgt_req;
  logic              ram_req;
  logic              sys_req;
  logic              none_req;
  bus_pkg::tgt_rsp_t ram_rsp;
  bus_pkg::tgt_rsp_t sys_rsp;
  logic              done;      // Result out, decoder free

  wb_decoder inst_wb_decoder (
    .wb_clk_i   (wb_clk_i ), .rst_n_i (rst_n_i ),
    .wbs_cyc_i  (wbs_cyc_i), .wbs_stb_i (wbs_stb_i), .wbs_we_i (wbs_we_i),
    .wbs_sel_i  (wbs_sel_i), .wbs_adr_i (wbs_adr_i), .wbs_dat_i (wbs_dat_i),
    .done_i     (done     ),
    .req_o      (tgt_req  ),
    .ram_req_o  (ram_req  ), .sys_req_o (sys_req  ), .none_req_o (none_req)
  );

  sram_target #(
    .ram_words  (ram_words)
  ) inst_sram_target (
    .wb_clk_i   (wb_clk_i ), .rst_n_i (rst_n_i ),
    .req_i      (tgt_req  ), .stb_i   (ram_req ), .rsp_o (ram_rsp)
  );

  sys_manager inst_sys_manager (
    .wb_clk_i     (wb_clk_i    ), .rst_n_i (rst_n_i ),
    .req_i        (tgt_req     ), .stb_i   (sys_req ), .rsp_o (sys_rsp),
    .proc_rst_n_o (proc_rst_n_o)
  );

  wb_responder inst_wb_responder (
    .wb_clk_i   (wb_clk_i ), .rst_n_i   (rst_n_i  ),
    .ram_rsp_i  (ram_rsp  ), .sys_rsp_i (sys_rsp  ), .none_req_i (none_req),
    .wbs_ack_o  (wbs_ack_o), .wbs_err_o (wbs_err_o), .wbs_dat_o  (wbs_dat_o),
    .done_o     (done     )
  );

endmodule

// File: map_pkg.sv
// Address map of the partition
// Two 4 kB windows, the target selector and the system register layout

package map_pkg;

  localparam logic [31:0] ram_base    = 32'h3000_0000;  // RAM window
  localparam logic [31:0] sys_base    = 32'h3000_1000;  // System manager window
  localparam int unsigned window_bits = 12;             // 4 kB per window

  // Decoded destination of a request
  typedef enum logic [1:0] {
    tgt_ram  = 2'd0,
    tgt_sys  = 2'd1,
    tgt_none = 2'd2   // Unmapped, answered with err
  } target_e;

  //////////////////////////////
  // System manager registers
  //////////////////////////////

  localparam logic [window_bits-1:0] sys_ctrl_off    = 12'h000;  // Bit 0 proc_run
  localparam logic [window_bits-1:0] sys_scratch_off = 12'h004;  // Free read/write word
  localparam logic [window_bits-1:0] sys_id_off      = 12'h008;  // Read only

  // Identification word
  localparam logic [31:0] sys_id_value = 32'h4d50_0001;

endpackage

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and decide on the log contents
cd "$(dirname "$0")" || exit 1

rm -f sim.log \
  && verilator --binary --timing --assert -f filelist.f \
       --top-module tb_main_partition -o sim_tb \
  && ./obj_dir/sim_tb | tee sim.log \
  && grep -qx '>>> PASS' sim.log \
  || { echo "Simulation did not pass"; exit 1; }

// File: sram_target.sv
// Word RAM target of the RAM window
// Byte lane writes, reads return the stored word one cycle after the strobe

`timescale 1ns/1ps

module sram_target #(
  parameter int unsigned ram_words = 256     // Depth in 32-bit words
) (
  input  logic              wb_clk_i,        // Wishbone clock
  input  logic              rst_n_i,         // Async reset, active low
  input  bus_pkg::tgt_req_t req_i,           // Registered request
  input  logic              stb_i,           // Access strobe
  output bus_pkg::tgt_rsp_t rsp_o
);

  localparam int unsigned idx_width = $clog2(ram_words);

  logic [bus_pkg::data_width-1:0] mem [ram_words];  // Storage array
  logic [idx_width-1:0]           idx;              // Word index
  logic                           rsp_valid;
  logic [bus_pkg::data_width-1:0] rsp_rdata;

  // Byte offset to word, wrapped on the RAM depth
  assign idx = idx_width'((req_i.offset >> 2) % ram_words);

  //////////////////////////////
  // Array write and read
  //////////////////////////////

  always_ff @(posedge wb_clk_i) begin
    if (stb_i && req_i.we) begin
      for (int b = 0; b < bus_pkg::sel_width; b++) begin
        if (req_i.sel[b]) begin
          mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];   // Selected lanes only
        end
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (stb_i) begin
      rsp_rdata <= req_i.we ? '0 : mem[idx];   // Writes answer zero
    end
  end

  // Response strobe
  always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= stb_i;
    end
  end

  assign rsp_o.valid = rsp_valid;
  assign rsp_o.rdata = rsp_rdata;

  // Index in range and a single strobe per access
  assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    stb_i |-> (idx < ram_words) ##1 !stb_i)
    else $error("sram_target: bad index or repeated strobe");

endmodule

// File: sys_manager.sv
// System manager target
// Control, scratch and id registers, drives the processor reset level

`timescale 1ns/1ps

module sys_manager (
  input  logic              wb_clk_i,       // Wishbone clock
  input  logic              rst_n_i,        // Async reset, active low
  input  bus_pkg::tgt_req_t req_i,          // Registered request
  input  logic              stb_i,          // Access strobe
  output bus_pkg::tgt_rsp_t rsp_o,
  output logic              proc_rst_n_o    // Processor reset, low holds core
);

  logic                           proc_run;   // ctrl bit 0
  logic [bus_pkg::data_width-1:0] scratch;
  logic [bus_pkg::data_width-1:0] rd_word;    // Read mux output
  logic                           rsp_valid;
  logic [bus_pkg::data_width-1:0] rsp_rdata;

  //////////////////////////////
  // Register writes
  //////////////////////////////

  always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      proc_run <= 1'b0;          // Core held after reset
      scratch  <= '0;
    end else if (stb_i && req_i.we) begin
      if (req_i.offset == map_pkg::sys_ctrl_off && req_i.sel[0]) begin
        proc_run <= req_i.wdata[0];
      end
      if (req_i.offset == map_pkg::sys_scratch_off) begin
        for (int b = 0; b < bus_pkg::sel_width; b++) begin
          if (req_i.sel[b]) begin
            scratch[8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // Read mux, unknown offsets read zero
  always_comb begin
    case (req_i.offset)
      map_pkg::sys_ctrl_off:    rd_word = {{(bus_pkg::data_width-1){1'b0}}, proc_run};
      map_pkg::sys_scratch_off: rd_word = scratch;
      map_pkg::sys_id_off:      rd_word = map_pkg::sys_id_value;
      default:                  rd_word = '0;
    endcase
  end

  //////////////////////////////
  // Response
  //////////////////////////////

  always_ff @(posedge wb_clk_i) begin
    if (stb_i) begin
      rsp_rdata <= req_i.we ? '0 : rd_word;   // Writes answer zero
    end
  end

  always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= stb_i;
    end
  end

  assign rsp_o.valid  = rsp_valid;
  assign rsp_o.rdata  = rsp_rdata;
  assign proc_rst_n_o = proc_run;   // Run bit releases the core

endmodule

// File: tb_main_partition.sv
// Testbench for the user partition top
// Random Wishbone traffic over the RAM, system manager and unmapped space,
// checked against a memory and register model

`timescale 1ns/1ps

module tb_main_partition;

  localparam int unsigned ram_words = 256;
  localparam int unsigned max_wait  = 20;    // Cycles before a response is given up
  localparam int unsigned num_ops   = 400;   // Random accesses

  logic        wb_clk_i;
  logic        rst_n_i;
  logic        wbs_cyc_i;
  logic        wbs_stb_i;
  logic        wbs_we_i;
  logic [3:0]  wbs_sel_i;
  logic [31:0] wbs_adr_i;
  logic [31:0] wbs_dat_i;
  logic        wbs_ack_o;
  logic        wbs_err_o;
  logic [31:0] wbs_dat_o;
  logic        proc_rst_n_o;

  int unsigned value_errs;
  int unsigned timing_errs;
  int unsigned timeout_errs;
  logic [31:0] rng;                          // xorshift state
  logic [31:0] model_mem [ram_words];        // RAM image
  logic        model_run;                    // ctrl bit 0
  logic [31:0] model_scratch;

  main_partition #(
    .ram_words (ram_words)
  ) dut_i (
    .wb_clk_i  (wb_clk_i ), .rst_n_i   (rst_n_i  ),
    .wbs_cyc_i (wbs_cyc_i), .wbs_stb_i (wbs_stb_i), .wbs_we_i  (wbs_we_i ),
    .wbs_sel_i (wbs_sel_i), .wbs_adr_i (wbs_adr_i), .wbs_dat_i (wbs_dat_i),
    .wbs_ack_o (wbs_ack_o), .wbs_err_o (wbs_err_o), .wbs_dat_o (wbs_dat_o),
    .proc_rst_n_o (proc_rst_n_o)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #4 wb_clk_i = ~wb_clk_i;   // 8 ns period
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Byte lane merge of a write into an old word
  function automatic logic [31:0] merge_lanes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] sel);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  // Initial RAM content, unique per word address
  function automatic logic [31:0] fill_word(input logic [7:0] a);
    return {a ^ 8'h5a, ~a, a, 8'h30};
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
      value_errs++;
    end
  endtask

  // One Wishbone classic cycle, stb held until ack or err
  task automatic bus_cycle(input logic we, input logic [3:0] sel, input logic [31:0] adr,
                           input logic [31:0] wdat, output logic ack, output logic err,
                           output logic [31:0] rdat);
    int unsigned waited;
    waited = 0;
    @(negedge wb_clk_i);
    wbs_cyc_i = 1'b1;
    wbs_stb_i = 1'b1;
    wbs_we_i  = we;
    wbs_sel_i = sel;
    wbs_adr_i = adr;
    wbs_dat_i = wdat;
    do begin
      @(negedge wb_clk_i);
      waited++;
    end while (!(wbs_ack_o || wbs_err_o) && waited < max_wait);
    ack  = wbs_ack_o;
    err  = wbs_err_o;
    rdat = wbs_dat_o;
    assert (ack || err) else begin
      $display("Error: no ack or err within %0d cycles at address 0x%08h", max_wait, adr);
      timeout_errs++;
    end
    // Sampling edge plus two register stages
    assert (!(ack || err) || waited == 3) else begin
      $display("Error at %0t ns: response latency = %0d, expected 3", $time, waited);
      timing_errs++;
    end
    wbs_cyc_i = 1'b0;
    wbs_stb_i = 1'b0;
    wbs_we_i  = 1'b0;
    @(negedge wb_clk_i);
    assert (!wbs_ack_o && !wbs_err_o) else begin
      $display("Error at %0t ns: ack or err held longer than one cycle", $time);
      timing_errs++;
    end
  endtask

  task automatic access(input logic we, input logic [3:0] sel, input logic [31:0] adr,
                        input logic [31:0] wdat, input logic exp_err, input logic [31:0] exp_rdat);
    logic        ack;
    logic        err;
    logic [31:0] rdat;
    bus_cycle(we, sel, adr, wdat, ack, err, rdat);
    check_word("wbs_ack_o", {31'b0, ack}, {31'b0, !exp_err});
    check_word("wbs_err_o", {31'b0, err}, {31'b0, exp_err});
    check_word("wbs_dat_o", rdat, exp_rdat);
  endtask

  //////////////////////////////
  // Model driven accesses
  //////////////////////////////

  task automatic ram_op(input logic we, input logic [7:0] idx, input logic [3:0] sel,
                        input logic [31:0] wdat);
    logic [31:0] exp;
    exp = we ? 32'h0 : model_mem[idx];   // Writes answer zero
    access(we, sel, map_pkg::ram_base | {22'b0, idx, 2'b00}, wdat, 1'b0, exp);
    if (we) model_mem[idx] = merge_lanes(model_mem[idx], wdat, sel);
  endtask

  task automatic sys_op(input logic we, input logic [11:0] off, input logic [3:0] sel,
                        input logic [31:0] wdat);
    logic [31:0] rd;
    case (off)
      12'h000: rd = {31'b0, model_run};
      12'h004: rd = model_scratch;
      12'h008: rd = 32'h4d50_0001;       // id constant
      default: rd = 32'h0;
    endcase
    access(we, sel, map_pkg::sys_base | {20'b0, off}, wdat, 1'b0, we ? 32'h0 : rd);
    if (we && off == 12'h000 && sel[0]) model_run = wdat[0];
    if (we && off == 12'h004) model_scratch = merge_lanes(model_scratch, wdat, sel);
    check_word("proc_rst_n_o", {31'b0, proc_rst_n_o}, {31'b0, model_run});
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    logic [31:0] adr;
    logic [31:0] wdat;
    value_errs    = 0;
    timing_errs   = 0;
    timeout_errs  = 0;
    rng           = 32'hed03;
    model_run     = 1'b0;
    model_scratch = 32'h0;
    rst_n_i   = 1'b0;
    wbs_cyc_i = 1'b0;
    wbs_stb_i = 1'b0;
    wbs_we_i  = 1'b0;
    wbs_sel_i = 4'h0;
    wbs_adr_i = 32'h0;
    wbs_dat_i = 32'h0;
    repeat (3) begin
      @(negedge wb_clk_i);
      check_word("wbs_ack_o", {31'b0, wbs_ack_o}, 32'h0);
      check_word("wbs_err_o", {31'b0, wbs_err_o}, 32'h0);
      check_word("proc_rst_n_o", {31'b0, proc_rst_n_o}, 32'h0);
    end
    rst_n_i = 1'b1;
    @(negedge wb_clk_i);
    check_word("wbs_ack_o", {31'b0, wbs_ack_o}, 32'h0);
    check_word("wbs_err_o", {31'b0, wbs_err_o}, 32'h0);
    check_word("wbs_dat_o", wbs_dat_o, 32'h0);
    check_word("proc_rst_n_o", {31'b0, proc_rst_n_o}, 32'h0);   // Core still held
    for (int i = 0; i < ram_words; i++) ram_op(1'b1, 8'(i), 4'hf, fill_word(8'(i)));
    // Run bit, lane 0 gating, id write ignored
    sys_op(1'b0, 12'h000, 4'hf, 32'h0);
    sys_op(1'b1, 12'h000, 4'hf, 32'h1);
    sys_op(1'b0, 12'h000, 4'hf, 32'h0);
    sys_op(1'b1, 12'h000, 4'he, 32'h0);
    sys_op(1'b1, 12'h008, 4'hf, 32'hffff_ffff);
    sys_op(1'b0, 12'h008, 4'hf, 32'h0);
    sys_op(1'b1, 12'h000, 4'h1, 32'h0);
    for (int n = 0; n < num_ops; n++) begin
      rng  = xorshift32(rng);
      wdat = xorshift32(rng);
      if (rng[2:0] < 3'd5) begin
        ram_op(rng[3], rng[15:8], rng[7:4], wdat);
      end else if (rng[2:0] < 3'd7) begin
        sys_op(rng[3], {8'b0, rng[17:16], 2'b00}, rng[7:4], wdat);
      end else begin
        adr = rng[20] ? (32'h3000_2000 | {20'b0, rng[31:22], 2'b00}) : wdat;
        if (adr[31:13] == 19'h18000) adr[31] = 1'b1;   // Keep out of both windows
        access(rng[3], rng[7:4], adr, wdat, 1'b1, 32'h0);
      end
      rng = wdat;
    end
    for (int i = 0; i < ram_words; i++) ram_op(1'b0, 8'(i), 4'hf, 32'h0);   // Final sweep
    sys_op(1'b0, 12'h004, 4'hf, 32'h0);
    $display("Errors: value %0d, timing %0d, timeout %0d", value_errs, timing_errs, timeout_errs);
    if (value_errs + timing_errs + timeout_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: wb_decoder.sv
// Wishbone classic request decoder
// Samples one cycle/strobe request, registers it and strobes the RAM,
// system manager or error path for a single cycle

`timescale 1ns/1ps

module wb_decoder (
  input  logic                           wb_clk_i,   // Wishbone clock
  input  logic                           rst_n_i,    // Async reset, active low
  // Wishbone slave request
  input  logic                           wbs_cyc_i,
  input  logic                           wbs_stb_i,
  input  logic                           wbs_we_i,
  input  logic [bus_pkg::sel_width-1:0]  wbs_sel_i,
  input  logic [bus_pkg::addr_width-1:0] wbs_adr_i,
  input  logic [bus_pkg::data_width-1:0] wbs_dat_i,
  input  logic                           done_i,     // Result stage has answered
  // Internal request bus
  output bus_pkg::tgt_req_t              req_o,
  output logic                           ram_req_o,  // RAM strobe
  output logic                           sys_req_o,  // System manager strobe
  output logic                           none_req_o  // Unmapped address
);

  localparam int unsigned hi_width = bus_pkg::addr_width - map_pkg::window_bits;

  // Window tags compared against the upper address bits
  localparam logic [hi_width-1:0] ram_hi = hi_width'(map_pkg::ram_base >> map_pkg::window_bits);
  localparam logic [hi_width-1:0] sys_hi = hi_width'(map_pkg::sys_base >> map_pkg::window_bits);

  logic                busy;    // Request in flight
  logic                take;    // Sample on this edge
  logic [hi_width-1:0] adr_hi;
  map_pkg::target_e    tgt;     // Decoded destination

  assign take   = wbs_cyc_i && wbs_stb_i && !busy;  // Held stb taken once
  assign adr_hi = wbs_adr_i[bus_pkg::addr_width-1:map_pkg::window_bits];

  //////////////////////////////
  // Address decode
  //////////////////////////////

  always_comb begin
    if (adr_hi == ram_hi) begin
      tgt = map_pkg::tgt_ram;
    end else if (adr_hi == sys_hi) begin
      tgt = map_pkg::tgt_sys;
    end else begin
      tgt = map_pkg::tgt_none;   // Falls to err path
    end
  end

  //////////////////////////////
  // Busy flag and strobes
  //////////////////////////////

  always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy       <= 1'b0;
      ram_req_o  <= 1'b0;
      sys_req_o  <= 1'b0;
      none_req_o <= 1'b0;
    end else begin
      if (take) begin
        busy <= 1'b1;
      end else if (done_i) begin
        busy <= 1'b0;            // Free once ack/err is out
      end
      ram_req_o  <= take && (tgt == map_pkg::tgt_ram);
      sys_req_o  <= take && (tgt == map_pkg::tgt_sys);
      none_req_o <= take && (tgt == map_pkg::tgt_none);
    end
  end

  // Request payload
  always_ff @(posedge wb_clk_i) begin
    if (take) begin
      req_o.we     <= wbs_we_i;
      req_o.sel    <= wbs_sel_i;
      req_o.offset <= wbs_adr_i[map_pkg::window_bits-1:0];
      req_o.wdata  <= wbs_dat_i;
    end
  end

  // No second strobe while the access is open, done returns two edges later
  assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    (ram_req_o || sys_req_o || none_req_o) |=>
      (!(ram_req_o || sys_req_o || none_req_o) && !done_i) ##1
      (!(ram_req_o || sys_req_o || none_req_o) && done_i))
    else $error("wb_decoder: strobe while busy or done out of step");

endmodule

// File: wb_responder.sv
// Wishbone result stage
// Merges target responses and the error path into registered ack, err and data

`timescale 1ns/1ps

module wb_responder (
  input  logic                           wb_clk_i,    // Wishbone clock
  input  logic                           rst_n_i,     // Async reset, active low
  input  bus_pkg::tgt_rsp_t              ram_rsp_i,
  input  bus_pkg::tgt_rsp_t              sys_rsp_i,
  input  logic                           none_req_i,  // Unmapped request strobe
  output logic                           wbs_ack_o,
  output logic                           wbs_err_o,
  output logic [bus_pkg::data_width-1:0] wbs_dat_o,
  output logic                           done_o       // Frees the decoder
);

  logic             none_d;   // Error path aligned to target latency
  map_pkg::target_e src;      // Source of this cycle's answer

  // Pick the valid source
  always_comb begin
    if (ram_rsp_i.valid) begin
      src = map_pkg::tgt_ram;
    end else if (sys_rsp_i.valid) begin
      src = map_pkg::tgt_sys;
    end else begin
      src = map_pkg::tgt_none;
    end
  end

  always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      none_d    <= 1'b0;
      wbs_ack_o <= 1'b0;
      wbs_err_o <= 1'b0;
      wbs_dat_o <= '0;
    end else begin
      none_d    <= none_req_i;
      wbs_ack_o <= ram_rsp_i.valid || sys_rsp_i.valid;
      wbs_err_o <= none_d;
      case (src)
        map_pkg::tgt_ram: wbs_dat_o <= ram_rsp_i.rdata;
        map_pkg::tgt_sys: wbs_dat_o <= sys_rsp_i.rdata;
        default:          wbs_dat_o <= '0;   // Idle and err read zero
      endcase
    end
  end

  assign done_o = wbs_ack_o || wbs_err_o;

  // Exclusive single-cycle answer
  assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    done_o |-> !(wbs_ack_o && wbs_err_o) ##1 !done_o)
    else $error("wb_responder: ack/err overlap or long pulse");

  // Only one request in flight across the targets
  assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    $onehot0({ram_rsp_i.valid, sys_rsp_i.valid, none_d}))
    else $error("wb_responder: two sources valid");

endmodule
